//--- hdl/axil_bus_pkg.sv
// Upstream AXI-lite bus definitions, imported by every module that faces the S_AXI port
`default_nettype none

package axil_bus_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus geometry
	//////////////////////////////////////////////////////////////////////

	// Data width is fixed, the byte lane layout depends on it
	localparam int AXIL_DW = 32;
	// One write strobe per byte lane
	localparam int AXIL_SW = AXIL_DW / 8;
	// Byte offset bits below the word index
	localparam int ADDR_LSBS = 2;

	//////////////////////////////////////////////////////////////////////
	// Field types
	//////////////////////////////////////////////////////////////////////

	typedef logic [1:0]         axil_resp_t;
	typedef logic [2:0]         axil_prot_t;
	typedef logic [AXIL_DW-1:0] axil_data_t;
	typedef logic [AXIL_SW-1:0] axil_strb_t;

	// One read return, also the word held in the read FIFO
	typedef struct packed {
		axil_data_t data;
		axil_resp_t resp;
	} axil_rbeat_t;

endpackage

`default_nettype wire

//--- hdl/slave_port_pkg.sv
// Simplified slave side definitions: broadcast buses and response codes for the register slaves
`default_nettype none

package slave_port_pkg;

	//////////////////////////////////////////////////////////////////////
	// Broadcast buses
	//////////////////////////////////////////////////////////////////////

	// Sent to every slave, only the strobed one acts on it
	typedef struct packed {
		axil_bus_pkg::axil_prot_t prot;
		axil_bus_pkg::axil_data_t data;
		axil_bus_pkg::axil_strb_t strb;
	} slave_wbus_t;

	// Read side only carries the protection bits
	typedef struct packed {
		axil_bus_pkg::axil_prot_t prot;
	} slave_rbus_t;

	//////////////////////////////////////////////////////////////////////
	// Response codes
	//////////////////////////////////////////////////////////////////////

	localparam axil_bus_pkg::axil_resp_t RESP_OKAY   = 2'b00;
	localparam axil_bus_pkg::axil_resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- hdl/addr_skid_buffer.sv
// One-entry skid buffer, keeps AWREADY a plain register while the write path stalls
`default_nettype none

module addr_skid_buffer #(
	parameter int DW = 7
) (
	input  logic          S_AXI_ACLK,
	input  logic          S_AXI_ARESETN,
	// Upstream side
	input  logic          i_valid,
	output logic          o_ready,
	input  logic [DW-1:0] i_data,
	// Downstream side
	output logic          o_valid,
	input  logic          i_ready,
	output logic [DW-1:0] o_data
);

	// Held entry
	logic          r_valid;
	logic [DW-1:0] r_data;

	//////////////////////////////////////////////////////////////////////
	// Entry control
	//////////////////////////////////////////////////////////////////////

	// Catch a beat that arrives while downstream is stalled
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			r_valid <= 1'b0;
		end
		else if (i_valid && o_ready && !i_ready)
		begin
			r_valid <= 1'b1;
		end
		else if (i_ready)
		begin
			// Held beat drained
			r_valid <= 1'b0;
		end
	end

	// Payload follows the input while the buffer is empty
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
		begin
			r_data <= i_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////////////////////////

	// Ready only depends on the buffer state
	assign o_ready = !r_valid;
	assign o_valid = i_valid || r_valid;
	// Held entry goes first
	assign o_data  = r_valid ? r_data : i_data;

endmodule

`default_nettype wire

//--- hdl/sync_fifo.sv
// Synchronous FIFO with registered output word, used for the B and R return queues
`default_nettype none

module sync_fifo #(
	parameter int BW     = 2,
	parameter int LGFLEN = 3
) (
	input  logic          S_AXI_ACLK,
	input  logic          S_AXI_ARESETN,
	// Write side
	input  logic          i_wr,
	input  logic [BW-1:0] i_data,
	// Read side
	input  logic          i_rd,
	output logic [BW-1:0] o_data,
	output logic          o_empty
);

	localparam int DEPTH = 1 << LGFLEN;

	logic [BW-1:0]   mem [DEPTH];
	// Pointers carry an extra wrap bit
	logic [LGFLEN:0] wr_ptr;
	logic [LGFLEN:0] rd_ptr;
	logic [LGFLEN:0] rd_next;
	logic            do_rd;

	//////////////////////////////////////////////////////////////////////
	// Pointers
	//////////////////////////////////////////////////////////////////////

	// Pops on an empty queue are ignored
	assign do_rd   = i_rd && !o_empty;
	assign rd_next = rd_ptr + {{LGFLEN{1'b0}}, do_rd};

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_wr)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			rd_ptr <= rd_next;
		end
	end

	assign o_empty = (wr_ptr == rd_ptr);

	//////////////////////////////////////////////////////////////////////
	// Storage and output word
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_wr)
		begin
			mem[wr_ptr[LGFLEN-1:0]] <= i_data;
		end
	end

	// Output always shows the head entry
	// Bypass when the entry being written becomes the new head
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_wr && (wr_ptr == rd_next))
		begin
			o_data <= i_data;
		end
		else
		begin
			o_data <= mem[rd_next[LGFLEN-1:0]];
		end
	end

endmodule

`default_nettype wire

//--- hdl/axil_single_write.sv
// Write path of the splitter: turns AW and W into a slave strobe and queues the BRESP
`default_nettype none

module axil_single_write #(
	parameter int NS     = 16,
	parameter int IW     = 4,
	parameter int LGFLEN = 3
) (
	input  logic                                 S_AXI_ACLK,
	input  logic                                 S_AXI_ARESETN,
	// Write address, index only
	input  logic                                 i_awvalid,
	input  logic [IW-1:0]                        i_awidx,
	input  axil_bus_pkg::axil_prot_t             i_awprot,
	output logic                                 o_awready,
	// Write data
	input  logic                                 i_wvalid,
	input  axil_bus_pkg::axil_data_t             i_wdata,
	input  axil_bus_pkg::axil_strb_t             i_wstrb,
	output logic                                 o_wready,
	// Write response
	input  logic                                 i_bready,
	output logic                                 o_bvalid,
	output axil_bus_pkg::axil_resp_t             o_bresp,
	// Slave side
	output logic [NS-1:0]                        o_m_awvalid,
	output slave_port_pkg::slave_wbus_t          o_m_wbus,
	input  axil_bus_pkg::axil_resp_t [NS-1:0]    i_m_bresp
);
	import axil_bus_pkg::*;
	import slave_port_pkg::*;

	localparam int SKW = IW + $bits(axil_prot_t);

	logic [SKW-1:0]  aw_data;
	logic            aw_valid;
	logic            aw_ready;
	logic            aw_accept;
	logic            w_fire;
	logic            b_fire;
	logic            b_empty;
	// Held select and its address
	logic            wready_q;
	logic [NS-1:0]   sel_q;
	axil_prot_t      prot_q;
	logic [IW-1:0]   windex;
	// Response pipeline, index and valid
	logic            b_wait;
	logic [IW-1:0]   bindex;
	logic            b_push;
	axil_resp_t      b_resp_q;
	// Outstanding writes
	logic [LGFLEN:0] count;
	logic            bfull;

	//////////////////////////////////////////////////////////////////////
	// Address intake and slave select
	//////////////////////////////////////////////////////////////////////

	addr_skid_buffer #(
		.DW(SKW)
	) u_awskid (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid      (i_awvalid),
		.o_ready      (o_awready),
		.i_data       ({i_awprot, i_awidx}),
		.o_valid      (aw_valid),
		.i_ready      (aw_ready),
		.o_data       (aw_data)
	);

	// Drain only once the previous W is done and the queue has room
	assign aw_ready  = (!wready_q || i_wvalid) && !bfull;
	assign aw_accept = aw_valid && aw_ready;
	assign w_fire    = i_wvalid && wready_q;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wready_q <= 1'b0;
			sel_q    <= '0;
		end
		else if (aw_accept)
		begin
			wready_q <= 1'b1;
			sel_q    <= {{(NS-1){1'b0}}, 1'b1} << aw_data[IW-1:0];
		end
		else if (i_wvalid)
		begin
			// W handshake ends the select
			wready_q <= 1'b0;
			sel_q    <= '0;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (aw_accept)
		begin
			prot_q <= aw_data[IW +: $bits(axil_prot_t)];
			windex <= aw_data[IW-1:0];
		end
	end

	// Strobe fires together with WVALID, W payload broadcast
	assign o_m_awvalid   = i_wvalid ? sel_q : '0;
	assign o_wready      = wready_q;
	assign o_m_wbus.prot = prot_q;
	assign o_m_wbus.data = i_wdata;
	assign o_m_wbus.strb = i_wstrb;

	//////////////////////////////////////////////////////////////////////
	// BRESP pipeline
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			b_wait   <= 1'b0;
			b_push   <= 1'b0;
			b_resp_q <= RESP_OKAY;
		end
		else
		begin
			b_wait   <= w_fire;
			b_push   <= b_wait;
			// Slave answer is valid the cycle after its strobe
			b_resp_q <= i_m_bresp[bindex];
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		bindex <= windex;
	end

	//////////////////////////////////////////////////////////////////////
	// Outstanding count and response queue
	//////////////////////////////////////////////////////////////////////

	assign b_fire = o_bvalid && i_bready;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			count <= '0;
			bfull <= 1'b0;
		end
		else if (aw_accept && !b_fire)
		begin
			count <= count + 1'b1;
			bfull <= &count[LGFLEN-1:0];
		end
		else if (b_fire && !aw_accept)
		begin
			count <= count - 1'b1;
			bfull <= 1'b0;
		end
	end

	sync_fifo #(
		.BW    ($bits(axil_resp_t)),
		.LGFLEN(LGFLEN)
	) u_bfifo (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_wr         (b_push),
		.i_data       (b_resp_q),
		.i_rd         (b_fire),
		.o_data       (o_bresp),
		.o_empty      (b_empty)
	);

	assign o_bvalid = !b_empty;

endmodule

`default_nettype wire

//--- hdl/axil_single_read.sv
// Read path of the splitter: strobes the addressed slave and queues its data and RRESP
`default_nettype none

module axil_single_read #(
	parameter int NS     = 16,
	parameter int IW     = 4,
	parameter int LGFLEN = 3
) (
	input  logic                                 S_AXI_ACLK,
	input  logic                                 S_AXI_ARESETN,
	// Read address, index only
	input  logic                                 i_arvalid,
	input  logic [IW-1:0]                        i_aridx,
	input  axil_bus_pkg::axil_prot_t             i_arprot,
	output logic                                 o_arready,
	// Read return
	input  logic                                 i_rready,
	output logic                                 o_rvalid,
	output axil_bus_pkg::axil_rbeat_t            o_rbeat,
	// Slave side
	output logic [NS-1:0]                        o_m_arvalid,
	output slave_port_pkg::slave_rbus_t          o_m_rbus,
	input  axil_bus_pkg::axil_rbeat_t [NS-1:0]   i_m_rbeat
);
	import axil_bus_pkg::*;
	import slave_port_pkg::*;

	logic            ar_fire;
	logic            r_fire;
	logic            r_empty;
	logic [NS-1:0]   arvalid_q;
	axil_prot_t      prot_q;
	// Three-stage valid pipeline with the index alongside
	logic            r_wait;
	logic            r_valid;
	logic            r_push;
	logic [IW-1:0]   rindex;
	logic [IW-1:0]   last_rindex;
	axil_rbeat_t     beat_q;
	// Outstanding reads
	logic [LGFLEN:0] count;
	logic            rfull;

	//////////////////////////////////////////////////////////////////////
	// Slave strobe
	//////////////////////////////////////////////////////////////////////

	assign ar_fire = i_arvalid && o_arready;

	// One cycle strobe per accepted address
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			arvalid_q <= '0;
			r_wait    <= 1'b0;
		end
		else if (ar_fire)
		begin
			arvalid_q <= {{(NS-1){1'b0}}, 1'b1} << i_aridx;
			r_wait    <= 1'b1;
		end
		else
		begin
			arvalid_q <= '0;
			r_wait    <= 1'b0;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ar_fire)
		begin
			prot_q <= i_arprot;
			rindex <= i_aridx;
		end
	end

	assign o_m_arvalid   = arvalid_q;
	assign o_m_rbus.prot = prot_q;

	//////////////////////////////////////////////////////////////////////
	// Return pipeline
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			r_valid <= 1'b0;
			r_push  <= 1'b0;
			beat_q  <= '{data: '0, resp: RESP_OKAY};
		end
		else
		begin
			r_valid <= r_wait;
			r_push  <= r_valid;
			// Beat of the slave strobed one cycle earlier
			beat_q  <= i_m_rbeat[last_rindex];
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		last_rindex <= rindex;
	end

	//////////////////////////////////////////////////////////////////////
	// Outstanding count and read queue
	//////////////////////////////////////////////////////////////////////

	assign r_fire = o_rvalid && i_rready;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			count <= '0;
			rfull <= 1'b0;
		end
		else if (ar_fire && !r_fire)
		begin
			count <= count + 1'b1;
			rfull <= &count[LGFLEN-1:0];
		end
		else if (r_fire && !ar_fire)
		begin
			count <= count - 1'b1;
			rfull <= 1'b0;
		end
	end

	// Room for one more read in flight
	assign o_arready = !rfull;

	sync_fifo #(
		.BW    ($bits(axil_rbeat_t)),
		.LGFLEN(LGFLEN)
	) u_rfifo (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_wr         (r_push),
		.i_data       (beat_q),
		.i_rd         (r_fire),
		.o_data       (o_rbeat),
		.o_empty      (r_empty)
	);

	assign o_rvalid = !r_empty;

endmodule

`default_nettype wire

//--- hdl/axil_single.sv
// Top of the AXI-lite splitter, connect S_AXI upstream and NS single-register slaves below
`default_nettype none

module axil_single #(
	parameter int  NS     = 16,
	parameter int  LGFLEN = 3,
	localparam int IW     = $clog2(NS)
) (
	input  logic                                     S_AXI_ACLK,
	input  logic                                     S_AXI_ARESETN,
	// Write address
	input  logic                                     i_s_awvalid,
	input  logic [IW+axil_bus_pkg::ADDR_LSBS-1:0]    i_s_awaddr,
	input  axil_bus_pkg::axil_prot_t                 i_s_awprot,
	output logic                                     o_s_awready,
	// Write data
	input  logic                                     i_s_wvalid,
	input  axil_bus_pkg::axil_data_t                 i_s_wdata,
	input  axil_bus_pkg::axil_strb_t                 i_s_wstrb,
	output logic                                     o_s_wready,
	// Write response
	output logic                                     o_s_bvalid,
	output axil_bus_pkg::axil_resp_t                 o_s_bresp,
	input  logic                                     i_s_bready,
	// Read address
	input  logic                                     i_s_arvalid,
	input  logic [IW+axil_bus_pkg::ADDR_LSBS-1:0]    i_s_araddr,
	input  axil_bus_pkg::axil_prot_t                 i_s_arprot,
	output logic                                     o_s_arready,
	// Read return
	output logic                                     o_s_rvalid,
	output axil_bus_pkg::axil_rbeat_t                o_s_rbeat,
	input  logic                                     i_s_rready,
	// Slave ports
	output logic [NS-1:0]                            o_m_awvalid,
	output slave_port_pkg::slave_wbus_t              o_m_wbus,
	input  axil_bus_pkg::axil_resp_t [NS-1:0]        i_m_bresp,
	output logic [NS-1:0]                            o_m_arvalid,
	output slave_port_pkg::slave_rbus_t              o_m_rbus,
	input  axil_bus_pkg::axil_rbeat_t [NS-1:0]       i_m_rbeat
);
	import axil_bus_pkg::*;

	// Word index selects the slave, byte offset is dropped
	logic [IW-1:0] awidx;
	logic [IW-1:0] aridx;

	assign awidx = i_s_awaddr[IW+ADDR_LSBS-1:ADDR_LSBS];
	assign aridx = i_s_araddr[IW+ADDR_LSBS-1:ADDR_LSBS];

	//////////////////////////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////////////////////////

	axil_single_write #(
		.NS    (NS),
		.IW    (IW),
		.LGFLEN(LGFLEN)
	) u_write (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_awvalid    (i_s_awvalid),
		.i_awidx      (awidx),
		.i_awprot     (i_s_awprot),
		.o_awready    (o_s_awready),
		.i_wvalid     (i_s_wvalid),
		.i_wdata      (i_s_wdata),
		.i_wstrb      (i_s_wstrb),
		.o_wready     (o_s_wready),
		.i_bready     (i_s_bready),
		.o_bvalid     (o_s_bvalid),
		.o_bresp      (o_s_bresp),
		.o_m_awvalid  (o_m_awvalid),
		.o_m_wbus     (o_m_wbus),
		.i_m_bresp    (i_m_bresp)
	);

	//////////////////////////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////////////////////////

	axil_single_read #(
		.NS    (NS),
		.IW    (IW),
		.LGFLEN(LGFLEN)
	) u_read (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_arvalid    (i_s_arvalid),
		.i_aridx      (aridx),
		.i_arprot     (i_s_arprot),
		.o_arready    (o_s_arready),
		.i_rready     (i_s_rready),
		.o_rvalid     (o_s_rvalid),
		.o_rbeat      (o_s_rbeat),
		.o_m_arvalid  (o_m_arvalid),
		.o_m_rbus     (o_m_rbus),
		.i_m_rbeat    (i_m_rbeat)
	);

endmodule

`default_nettype wire

//--- dv/tb_slave_bank.sv
// Model of NS single-register slaves that answer each strobe one cycle later, used by the testbench
`default_nettype none

module tb_slave_bank #(
	parameter int NS = 16
) (
	input  logic                                 S_AXI_ACLK,
	input  logic                                 S_AXI_ARESETN,
	input  logic [NS-1:0]                        i_awvalid,
	input  slave_port_pkg::slave_wbus_t          i_wbus,
	output axil_bus_pkg::axil_resp_t [NS-1:0]    o_bresp,
	input  logic [NS-1:0]                        i_arvalid,
	output axil_bus_pkg::axil_rbeat_t [NS-1:0]   o_rbeat
);
	timeunit 1ns;
	timeprecision 100ps;
	import axil_bus_pkg::*;
	import slave_port_pkg::*;

	axil_data_t regs [NS];

	// Odd slaves answer SLVERR and even ones OKAY
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			for (int k = 0; k < NS; k++)
			begin
				regs[k]    <= '0;
				o_bresp[k] <= RESP_OKAY;
				o_rbeat[k] <= '{data: '0, resp: RESP_OKAY};
			end
		end
		else
		begin
			for (int k = 0; k < NS; k++)
			begin
				if (i_awvalid[k])
				begin
					// Only the strobed byte lanes change
					for (int b = 0; b < AXIL_SW; b++)
					begin
						if (i_wbus.strb[b])
						begin
							regs[k][8*b +: 8] <= i_wbus.data[8*b +: 8];
						end
					end
					o_bresp[k] <= (k % 2 == 1) ? RESP_SLVERR : RESP_OKAY;
				end
				if (i_arvalid[k])
				begin
					o_rbeat[k] <= '{data: regs[k],
						resp: (k % 2 == 1) ? RESP_SLVERR : RESP_OKAY};
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- dv/tb_axil_single.sv
// Testbench of the AXI-lite splitter that drives S_AXI and checks every response against a shadow model
`default_nettype none

module tb_axil_single;
	timeunit 1ns;
	timeprecision 100ps;
	import axil_bus_pkg::*;
	import slave_port_pkg::*;

	localparam int NS     = 16;
	localparam int LGFLEN = 3;
	localparam int N_RAND = 20;
	localparam int N_BP   = 12;
	localparam int N_MIX  = 40;
	// Every write and every read counts as one transaction
	localparam int N_TXN  = 2 * NS + 2 * N_RAND + 2 * N_BP + 2 * N_MIX;

	logic S_AXI_ACLK = 1'b0;
	logic S_AXI_ARESETN;
	logic awvalid, wvalid, bready, arvalid, rready;
	logic [5:0] awaddr, araddr;
	axil_prot_t awprot, arprot;
	axil_data_t wdata;
	axil_strb_t wstrb;
	logic awready, wready, bvalid, arready, rvalid;
	axil_resp_t bresp;
	axil_rbeat_t rbeat;
	logic [NS-1:0] m_awvalid, m_arvalid;
	slave_wbus_t m_wbus;
	slave_rbus_t m_rbus;
	axil_resp_t [NS-1:0] m_bresp;
	axil_rbeat_t [NS-1:0] m_rbeat;

	integer seed;
	// Mode 0 holds ready high, 1 holds it low and 2 adds random gaps
	int ready_mode;
	int aw_count, ar_count;
	axil_data_t shadow [NS];
	// Pending jobs for the drivers
	int aw_jobs[$];
	int ar_jobs[$];
	logic [35:0] w_jobs[$];
	// Expected responses in issue order
	axil_resp_t exp_b[$];
	axil_rbeat_t exp_r[$];
	// Accepted prot and index waiting for their slave strobe
	int aw_sent[$];
	int ar_sent[$];

	axil_single #(
		.NS    (NS),
		.LGFLEN(LGFLEN)
	) i_dut (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_s_awvalid  (awvalid),
		.i_s_awaddr   (awaddr),
		.i_s_awprot   (awprot),
		.o_s_awready  (awready),
		.i_s_wvalid   (wvalid),
		.i_s_wdata    (wdata),
		.i_s_wstrb    (wstrb),
		.o_s_wready   (wready),
		.o_s_bvalid   (bvalid),
		.o_s_bresp    (bresp),
		.i_s_bready   (bready),
		.i_s_arvalid  (arvalid),
		.i_s_araddr   (araddr),
		.i_s_arprot   (arprot),
		.o_s_arready  (arready),
		.o_s_rvalid   (rvalid),
		.o_s_rbeat    (rbeat),
		.i_s_rready   (rready),
		.o_m_awvalid  (m_awvalid),
		.o_m_wbus     (m_wbus),
		.i_m_bresp    (m_bresp),
		.o_m_arvalid  (m_arvalid),
		.o_m_rbus     (m_rbus),
		.i_m_rbeat    (m_rbeat)
	);

	tb_slave_bank #(
		.NS(NS)
	) u_slaves (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_awvalid    (m_awvalid),
		.i_wbus       (m_wbus),
		.o_bresp      (m_bresp),
		.i_arvalid    (m_arvalid),
		.o_rbeat      (m_rbeat)
	);

	always #4 S_AXI_ACLK = ~S_AXI_ACLK;

	//////////////////////////////////////////////////////////////////////
	// Reporting and reference model
	//////////////////////////////////////////////////////////////////////

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	// Merge strobed bytes into the shadow and return the response by slave parity
	function automatic axil_resp_t ref_write(input int idx, input axil_data_t data,
		input axil_strb_t strb);
		for (int b = 0; b < AXIL_SW; b++)
		begin
			if (strb[b])
			begin
				shadow[idx][8*b +: 8] = data[8*b +: 8];
			end
		end
		return (idx % 2 == 1) ? RESP_SLVERR : RESP_OKAY;
	endfunction

	function automatic axil_rbeat_t ref_read(input int idx);
		axil_rbeat_t beat;
		beat.data = shadow[idx];
		beat.resp = (idx % 2 == 1) ? RESP_SLVERR : RESP_OKAY;
		return beat;
	endfunction

	task automatic queue_write(input int idx, input axil_data_t data, input axil_strb_t strb);
		aw_jobs.push_back(idx);
		w_jobs.push_back({strb, data});
		exp_b.push_back(ref_write(idx, data, strb));
	endtask

	task automatic queue_read(input int idx);
		ar_jobs.push_back(idx);
		exp_r.push_back(ref_read(idx));
	endtask

	task automatic wait_idle();
		@(posedge S_AXI_ACLK);
		while (aw_jobs.size() != 0 || w_jobs.size() != 0 || ar_jobs.size() != 0 ||
			exp_b.size() != 0 || exp_r.size() != 0 || awvalid || wvalid || arvalid)
		begin
			@(posedge S_AXI_ACLK);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Channel drivers acting 1 ns after the edge
	//////////////////////////////////////////////////////////////////////

	always @(posedge S_AXI_ACLK)
	begin
		logic fire;
		logic [31:0] r;
		int idx;
		fire = awvalid && awready;
		if (fire)
		begin
			aw_sent.push_back(int'({awprot, awaddr[5:2]}));
			aw_count++;
		end
		#1;
		if (fire || !awvalid)
		begin
			if (S_AXI_ARESETN && aw_jobs.size() != 0)
			begin
				idx = aw_jobs.pop_front();
				r = $random(seed);
				awvalid = 1'b1;
				awaddr = {idx[3:0], r[1:0]};
				awprot = r[4:2];
			end
			else
			begin
				awvalid = 1'b0;
			end
		end
	end

	always @(posedge S_AXI_ACLK)
	begin
		logic fire;
		logic [35:0] job;
		fire = wvalid && wready;
		#1;
		if (fire || !wvalid)
		begin
			if (S_AXI_ARESETN && w_jobs.size() != 0)
			begin
				job = w_jobs.pop_front();
				wvalid = 1'b1;
				{wstrb, wdata} = job;
			end
			else
			begin
				wvalid = 1'b0;
			end
		end
	end

	always @(posedge S_AXI_ACLK)
	begin
		logic fire;
		logic [31:0] r;
		int idx;
		fire = arvalid && arready;
		if (fire)
		begin
			ar_sent.push_back(int'({arprot, araddr[5:2]}));
			ar_count++;
		end
		#1;
		if (fire || !arvalid)
		begin
			if (S_AXI_ARESETN && ar_jobs.size() != 0)
			begin
				idx = ar_jobs.pop_front();
				r = $random(seed);
				arvalid = 1'b1;
				araddr = {idx[3:0], r[1:0]};
				arprot = r[4:2];
			end
			else
			begin
				arvalid = 1'b0;
			end
		end
	end

	// B and R ready per test mode
	always @(posedge S_AXI_ACLK)
	begin
		logic [31:0] r;
		#1;
		case (ready_mode)
			0:
			begin
				bready = 1'b1;
				rready = 1'b1;
			end
			1:
			begin
				bready = 1'b0;
				rready = 1'b0;
			end
			default:
			begin
				r = $random(seed);
				bready = r[0] | r[1];
				rready = r[2] | r[3];
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Comparison and strobe monitor
	//////////////////////////////////////////////////////////////////////

	always @(posedge S_AXI_ACLK)
	begin
		axil_rbeat_t exp_beat;
		if (S_AXI_ARESETN && bvalid && bready)
		begin
			if (exp_b.size() == 0)
				fail_run("Write response arrived with no write outstanding");
			check_value("o_s_bresp", 64'(bresp), 64'(exp_b.pop_front()));
		end
		if (S_AXI_ARESETN && rvalid && rready)
		begin
			if (exp_r.size() == 0)
				fail_run("Read data arrived with no read outstanding");
			exp_beat = exp_r.pop_front();
			check_value("o_s_rbeat.data", 64'(rbeat.data), 64'(exp_beat.data));
			check_value("o_s_rbeat.resp", 64'(rbeat.resp), 64'(exp_beat.resp));
		end
	end

	// One-hot strobe and prot of the accepted slave sampled mid-cycle
	always @(negedge S_AXI_ACLK)
	begin
		int sent;
		if (S_AXI_ARESETN && m_awvalid != '0)
		begin
			if (aw_sent.size() == 0)
				fail_run("Slave write strobe without an accepted address");
			sent = aw_sent.pop_front();
			check_value("o_m_awvalid", 64'(m_awvalid), 64'(1) << sent[3:0]);
			check_value("o_m_wbus.prot", 64'(m_wbus.prot), 64'(sent[6:4]));
		end
		if (S_AXI_ARESETN && m_arvalid != '0)
		begin
			if (ar_sent.size() == 0)
				fail_run("Slave read strobe without an accepted address");
			sent = ar_sent.pop_front();
			check_value("o_m_arvalid", 64'(m_arvalid), 64'(1) << sent[3:0]);
			check_value("o_m_rbus.prot", 64'(m_rbus.prot), 64'(sent[6:4]));
		end
	end

	// Watchdog sized by the transaction count plus reset
	initial
	begin
		#((5 + 40 + 20 * N_TXN) * 8);
		fail_run("Timeout: the run did not finish in time");
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0] r;
		logic [31:0] d;
		int base;
		int low_run;
		seed = 32'h22857f3e;
		ready_mode = 0;
		aw_count = 0;
		ar_count = 0;
		awvalid = 1'b0;
		awaddr = '0;
		awprot = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b1;
		arvalid = 1'b0;
		araddr = '0;
		arprot = '0;
		rready = 1'b1;
		for (int k = 0; k < NS; k++)
			shadow[k] = '0;
		S_AXI_ARESETN = 1'b0;
		repeat (5) @(posedge S_AXI_ACLK);
		#1 S_AXI_ARESETN = 1'b1;

		// Idle state after reset
		repeat (3) @(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		check_value("o_s_bvalid", 64'(bvalid), 64'(0));
		check_value("o_s_rvalid", 64'(rvalid), 64'(0));
		check_value("o_s_wready", 64'(wready), 64'(0));
		check_value("o_m_awvalid", 64'(m_awvalid), 64'(0));
		check_value("o_m_arvalid", 64'(m_arvalid), 64'(0));
		check_value("o_s_awready", 64'(awready), 64'(1));
		check_value("o_s_arready", 64'(arready), 64'(1));

		// Distinct full word per slave and read back
		for (int k = 0; k < NS; k++)
			queue_write(k, 32'hC0DE0000 + k * 32'h00011111, 4'hf);
		wait_idle();
		for (int k = 0; k < NS; k++)
			queue_read(k);
		wait_idle();

		// Random partial strobes
		for (int n = 0; n < N_RAND; n++)
		begin
			r = $random(seed);
			d = $random(seed);
			queue_write(int'(r[3:0]), d, r[7:4]);
		end
		wait_idle();
		for (int n = 0; n < N_RAND; n++)
		begin
			r = $random(seed);
			queue_read(int'(r[3:0]));
		end
		wait_idle();

		// Write back-pressure lets AWREADY fall after at most 9 accepts
		ready_mode = 1;
		repeat (2) @(posedge S_AXI_ACLK);
		base = aw_count;
		for (int n = 0; n < N_BP; n++)
			queue_write(n % NS, 32'h5A000000 + n, 4'hf);
		low_run = 0;
		for (int c = 0; c < 60 && low_run < 4; c++)
		begin
			@(negedge S_AXI_ACLK);
			low_run = awready ? 0 : low_run + 1;
		end
		if (low_run < 4)
			fail_run("AWREADY did not fall while BREADY was held low");
		if (aw_count - base > 9)
			fail_run("More than 9 write addresses accepted while BREADY was low");
		ready_mode = 0;
		wait_idle();

		// Read back-pressure
		ready_mode = 1;
		repeat (2) @(posedge S_AXI_ACLK);
		base = ar_count;
		for (int n = 0; n < N_BP; n++)
			queue_read(n % NS);
		low_run = 0;
		for (int c = 0; c < 60 && low_run < 4; c++)
		begin
			@(negedge S_AXI_ACLK);
			low_run = arready ? 0 : low_run + 1;
		end
		if (low_run < 4)
			fail_run("ARREADY did not fall while RREADY was held low");
		if (ar_count - base > 9)
			fail_run("More than 9 read addresses accepted while RREADY was low");
		ready_mode = 0;
		wait_idle();

		// Interleaved writes to 0..7 and reads from 8..15
		ready_mode = 2;
		for (int n = 0; n < N_MIX; n++)
		begin
			r = $random(seed);
			d = $random(seed);
			queue_write(int'(r[2:0]), d, r[7:4]);
			queue_read(8 + int'(r[10:8]));
		end
		wait_idle();
		ready_mode = 0;
		repeat (4) @(posedge S_AXI_ACLK);

		if (aw_sent.size() != 0 || ar_sent.size() != 0)
		begin
			fail_run("Some accepted addresses never produced a slave strobe");
		end
		else
		begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- axil_single.f
hdl/axil_bus_pkg.sv
hdl/slave_port_pkg.sv
hdl/addr_skid_buffer.sv
hdl/sync_fifo.sv
hdl/axil_single_write.sv
hdl/axil_single_read.sv
hdl/axil_single.sv
dv/tb_slave_bank.sv
dv/tb_axil_single.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
mkdir -p build
verilator --binary --timing -Wno-fatal --top-module tb_axil_single \
	-f axil_single.f --Mdir build/obj -o tb_axil_single
./build/obj/tb_axil_single | tee build/sim.log
if grep -q "FAIL: see errors above" build/sim.log; then
	exit 1
fi
if ! grep -q "PASS: all tests" build/sim.log; then
	exit 1
fi
exit 0
